// ==== run.sh ====
#!/bin/sh
# compile and run the scoreboard testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -sv -Wno-fatal --top-module sbt_tb -f tb.f -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vsbt_tb +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^SIMULATION PASSED$" sim.log; then
  exit 0
fi
exit 1

// ==== source/sbt_addr_classify.sv ====
`timescale 1ns/1ps

module sbt_addr_classify (
  input  sbt_pkg::op_e                         id_op_i,
  input  logic [sbt_pkg::imm_width-1:0]        id_imm_i,
  input  logic [sbt_pkg::data_width-1:0]       id_rs1_val_i,
  input  logic [sbt_pkg::x_cord_width-1:0]     my_x_i,
  input  logic [sbt_pkg::y_cord_width-1:0]     my_y_i,
  output logic                                 remote_dram_o,
  output logic                                 remote_global_o,
  output logic                                 remote_group_o
);

  localparam int dw = sbt_pkg::data_width;

  logic                    is_load;
  logic                    is_amo;
  logic                    is_mem;
  logic [sbt_pkg::imm_width-1:0] imm;
  logic [dw-1:0]           imm_ext;
  logic [dw-1:0]           addr;
  logic [sbt_pkg::x_cord_width-1:0] addr_x;
  logic [sbt_pkg::y_cord_width-1:0] addr_y;
  logic                    is_my_tile;
  logic                    group_region;

  assign is_load = (id_op_i == sbt_pkg::op_load) || (id_op_i == sbt_pkg::op_flw);
  assign is_amo  = (id_op_i == sbt_pkg::op_amo);
  assign is_mem  = is_load || is_amo;

  // amo carries no offset, the address is rs1 as is
  assign imm     = is_amo ? '0 : id_imm_i;
  assign imm_ext = {{(dw - sbt_pkg::imm_width){imm[sbt_pkg::imm_width-1]}}, imm};
  assign addr    = id_rs1_val_i + imm_ext;

  // coordinate fields of a tile group address
  assign addr_x = addr[sbt_pkg::x_cord_lsb +: sbt_pkg::x_cord_width];
  assign addr_y = addr[sbt_pkg::y_cord_lsb +: sbt_pkg::y_cord_width];
  assign is_my_tile = (addr_x == my_x_i) && (addr_y == my_y_i);

  assign group_region = (addr[dw-1 -: 3] == 3'b001);

  assign remote_dram_o   = is_mem && addr[dw-1];
  assign remote_global_o = is_mem && (addr[dw-1 -: 2] == 2'b01);

  // a load to the own tile is served locally, an amo still goes out
  assign remote_group_o  = is_mem && group_region && (!is_my_tile || is_amo);

endmodule

// ==== source/sbt_decode.sv ====
`timescale 1ns/1ps

module sbt_decode (
  input  logic                                 clk_i,
  input  logic                                 reset_i,
  input  logic                                 instr_valid_i,
  input  logic [31:0]                          instr_i,
  input  logic [sbt_pkg::data_width-1:0]       rs1_val_i,
  input  logic                                 stall_i,
  input  logic                                 flush_i,
  output logic                                 id_valid_o,
  output sbt_pkg::op_e                         id_op_o,
  output logic [sbt_pkg::reg_addr_width-1:0]   id_rd_o,
  output logic [sbt_pkg::imm_width-1:0]        id_imm_o,
  output logic [sbt_pkg::data_width-1:0]       id_rs1_val_o,
  output logic                                 id_write_rd_o
);

  logic [6:0]                        opcode;
  logic [2:0]                        funct3;
  logic [6:0]                        funct7;
  logic [sbt_pkg::reg_addr_width-1:0] rd;
  sbt_pkg::op_e                      op_dec;
  logic                              write_rd_dec;

  assign opcode = instr_i[6:0];
  assign rd     = instr_i[11:7];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  always_comb begin
    op_dec = sbt_pkg::op_none;
    case (opcode)
      sbt_pkg::opc_load: op_dec = sbt_pkg::op_load;
      sbt_pkg::opc_load_fp: begin
        if (funct3 == sbt_pkg::f3_word) op_dec = sbt_pkg::op_flw;
      end
      sbt_pkg::opc_amo: begin
        if (funct3 == sbt_pkg::f3_word) op_dec = sbt_pkg::op_amo;
      end
      sbt_pkg::opc_op: begin
        // div, divu, rem, remu have funct3[2] set
        if (funct7 == sbt_pkg::f7_muldiv && funct3[2]) op_dec = sbt_pkg::op_idiv;
      end
      sbt_pkg::opc_op_fp: begin
        if (funct7 == sbt_pkg::f7_fdiv) op_dec = sbt_pkg::op_fdiv;
        else if (funct7 == sbt_pkg::f7_fsqrt) op_dec = sbt_pkg::op_fsqrt;
      end
      default: op_dec = sbt_pkg::op_none;
    endcase
  end

  // x0 is never written, so such a load needs no tracking
  assign write_rd_dec = (op_dec == sbt_pkg::op_load) && (rd != '0);

  // id stage register
  always_ff @(posedge clk_i) begin
    if (reset_i || flush_i) begin
      id_valid_o <= 1'b0;
    end else if (!stall_i) begin
      id_valid_o <= instr_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!stall_i) begin
      id_op_o       <= op_dec;
      id_rd_o       <= rd;
      id_imm_o      <= instr_i[31:20];
      id_rs1_val_o  <= rs1_val_i;
      id_write_rd_o <= write_rd_dec;
    end
  end

endmodule

// ==== source/sbt_pkg.sv ====
package sbt_pkg;

  // machine word and register file
  localparam int data_width     = 32;
  localparam int reg_els        = 32;
  localparam int reg_addr_width = 5;
  localparam int imm_width      = 12;

  // tile group address layout
  localparam int x_cord_width = 6;
  localparam int y_cord_width = 5;
  localparam int x_cord_lsb   = 18;
  localparam int y_cord_lsb   = 24;

  // integer scoreboard bits per register
  localparam int int_classes     = 6;
  localparam int isb_idiv        = 0;
  localparam int isb_dram_load   = 1;
  localparam int isb_dram_amo    = 2;
  localparam int isb_global_load = 3;
  localparam int isb_group_load  = 4;
  localparam int isb_group_amo   = 5;

  // float scoreboard bits per register
  localparam int float_classes   = 4;
  localparam int fsb_fdiv_fsqrt  = 0;
  localparam int fsb_dram_load   = 1;
  localparam int fsb_global_load = 2;
  localparam int fsb_group_load  = 3;

  // rv32 major opcodes and function fields
  localparam logic [6:0] opc_load    = 7'b0000011;
  localparam logic [6:0] opc_load_fp = 7'b0000111;
  localparam logic [6:0] opc_amo     = 7'b0101111;
  localparam logic [6:0] opc_op      = 7'b0110011;
  localparam logic [6:0] opc_op_fp   = 7'b1010011;
  localparam logic [2:0] f3_word     = 3'b010;
  localparam logic [6:0] f7_muldiv   = 7'b0000001;
  localparam logic [6:0] f7_fdiv     = 7'b0001100;
  localparam logic [6:0] f7_fsqrt    = 7'b0101100;

  // long-latency operation started by the instruction in id
  typedef enum logic [2:0] {
    op_none,
    op_load,
    op_flw,
    op_amo,
    op_idiv,
    op_fdiv,
    op_fsqrt
  } op_e;

endpackage

// ==== source/sbt_top.sv ====
`timescale 1ns/1ps

module sbt_top (
  input  logic                                 clk_i,
  input  logic                                 reset_i,
  input  logic                                 instr_valid_i,
  input  logic [31:0]                          instr_i,
  input  logic [sbt_pkg::data_width-1:0]       rs1_val_i,
  input  logic                                 stall_i,
  input  logic                                 flush_i,
  input  logic [sbt_pkg::x_cord_width-1:0]     my_x_i,
  input  logic [sbt_pkg::y_cord_width-1:0]     my_y_i,
  input  logic                                 int_clear_i,
  input  logic [sbt_pkg::reg_addr_width-1:0]   int_clear_id_i,
  input  logic                                 float_clear_i,
  input  logic [sbt_pkg::reg_addr_width-1:0]   float_clear_id_i,
  output logic [sbt_pkg::reg_els-1:0][sbt_pkg::int_classes-1:0]   int_sb_o,
  output logic [sbt_pkg::reg_els-1:0][sbt_pkg::float_classes-1:0] float_sb_o
);

  // id stage fields
  logic                               id_valid;
  sbt_pkg::op_e                       id_op;
  logic [sbt_pkg::reg_addr_width-1:0] id_rd;
  logic [sbt_pkg::imm_width-1:0]      id_imm;
  logic [sbt_pkg::data_width-1:0]     id_rs1_val;
  logic                               id_write_rd;

  // region of the id access
  logic remote_dram;
  logic remote_global;
  logic remote_group;

  sbt_decode decode_i (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .rs1_val_i     (rs1_val_i),
    .stall_i       (stall_i),
    .flush_i       (flush_i),
    .id_valid_o    (id_valid),
    .id_op_o       (id_op),
    .id_rd_o       (id_rd),
    .id_imm_o      (id_imm),
    .id_rs1_val_o  (id_rs1_val),
    .id_write_rd_o (id_write_rd)
  );

  sbt_addr_classify classify_i (
    .id_op_i         (id_op),
    .id_imm_i        (id_imm),
    .id_rs1_val_i    (id_rs1_val),
    .my_x_i          (my_x_i),
    .my_y_i          (my_y_i),
    .remote_dram_o   (remote_dram),
    .remote_global_o (remote_global),
    .remote_group_o  (remote_group)
  );

  sbt_tracker tracker_i (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .stall_i          (stall_i),
    .flush_i          (flush_i),
    .id_valid_i       (id_valid),
    .id_op_i          (id_op),
    .id_rd_i          (id_rd),
    .id_write_rd_i    (id_write_rd),
    .remote_dram_i    (remote_dram),
    .remote_global_i  (remote_global),
    .remote_group_i   (remote_group),
    .int_clear_i      (int_clear_i),
    .int_clear_id_i   (int_clear_id_i),
    .float_clear_i    (float_clear_i),
    .float_clear_id_i (float_clear_id_i),
    .int_sb_o         (int_sb_o),
    .float_sb_o       (float_sb_o)
  );

endmodule

// ==== source/sbt_tracker.sv ====
`timescale 1ns/1ps

module sbt_tracker (
  input  logic                                 clk_i,
  input  logic                                 reset_i,
  input  logic                                 stall_i,
  input  logic                                 flush_i,
  input  logic                                 id_valid_i,
  input  sbt_pkg::op_e                         id_op_i,
  input  logic [sbt_pkg::reg_addr_width-1:0]   id_rd_i,
  input  logic                                 id_write_rd_i,
  input  logic                                 remote_dram_i,
  input  logic                                 remote_global_i,
  input  logic                                 remote_group_i,
  input  logic                                 int_clear_i,
  input  logic [sbt_pkg::reg_addr_width-1:0]   int_clear_id_i,
  input  logic                                 float_clear_i,
  input  logic [sbt_pkg::reg_addr_width-1:0]   float_clear_id_i,
  output logic [sbt_pkg::reg_els-1:0][sbt_pkg::int_classes-1:0]   int_sb_o,
  output logic [sbt_pkg::reg_els-1:0][sbt_pkg::float_classes-1:0] float_sb_o
);

  logic                              set_ok;
  logic                              int_load;
  logic                              is_amo;
  logic                              is_flw;
  logic [sbt_pkg::int_classes-1:0]   int_set;
  logic [sbt_pkg::float_classes-1:0] float_set;

  logic [sbt_pkg::reg_els-1:0][sbt_pkg::int_classes-1:0]   int_sb_r;
  logic [sbt_pkg::reg_els-1:0][sbt_pkg::float_classes-1:0] float_sb_r;

  // id entry leaves for exe this cycle
  assign set_ok   = id_valid_i && !stall_i && !flush_i;
  assign int_load = (id_op_i == sbt_pkg::op_load) && id_write_rd_i;
  assign is_amo   = (id_op_i == sbt_pkg::op_amo);
  assign is_flw   = (id_op_i == sbt_pkg::op_flw);

  always_comb begin
    int_set = '0;
    int_set[sbt_pkg::isb_idiv]        = id_op_i == sbt_pkg::op_idiv;
    int_set[sbt_pkg::isb_dram_load]   = int_load && remote_dram_i;
    int_set[sbt_pkg::isb_dram_amo]    = is_amo && remote_dram_i;
    // global amo shares the global load bit
    int_set[sbt_pkg::isb_global_load] = (int_load || is_amo) && remote_global_i;
    int_set[sbt_pkg::isb_group_load]  = int_load && remote_group_i;
    int_set[sbt_pkg::isb_group_amo]   = is_amo && remote_group_i;
    if (!set_ok) int_set = '0;
  end

  always_comb begin
    float_set = '0;
    float_set[sbt_pkg::fsb_fdiv_fsqrt]  = (id_op_i == sbt_pkg::op_fdiv) ||
                                          (id_op_i == sbt_pkg::op_fsqrt);
    float_set[sbt_pkg::fsb_dram_load]   = is_flw && remote_dram_i;
    float_set[sbt_pkg::fsb_global_load] = is_flw && remote_global_i;
    float_set[sbt_pkg::fsb_group_load]  = is_flw && remote_group_i;
    if (!set_ok) float_set = '0;
  end

  // per bit, a set in the same cycle beats the clear
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      int_sb_r <= '0;
    end else begin
      for (int i = 0; i < sbt_pkg::reg_els; i++) begin
        if (int_clear_i && (int_clear_id_i == i)) int_sb_r[i] <= '0;
        if (id_rd_i == i) int_sb_r[i] <= int_set |
            (int_sb_r[i] & {sbt_pkg::int_classes{!(int_clear_i && (int_clear_id_i == i))}});
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      float_sb_r <= '0;
    end else begin
      for (int i = 0; i < sbt_pkg::reg_els; i++) begin
        if (float_clear_i && (float_clear_id_i == i)) float_sb_r[i] <= '0;
        if (id_rd_i == i) float_sb_r[i] <= float_set |
            (float_sb_r[i] & {sbt_pkg::float_classes{!(float_clear_i && (float_clear_id_i == i))}});
      end
    end
  end

  assign int_sb_o   = int_sb_r;
  assign float_sb_o = float_sb_r;

endmodule

// ==== tb.f ====
source/sbt_pkg.sv
source/sbt_decode.sv
source/sbt_addr_classify.sv
source/sbt_tracker.sv
source/sbt_top.sv
verification/sbt_asserts.sv
verification/sbt_checker.sv
verification/sbt_tb.sv

// ==== verification/sbt_asserts.sv ====
`timescale 1ns/1ps

module sbt_asserts (
  input logic                                 clk_i,
  input logic                                 reset_i,
  input logic                                 set_ok_i,
  input logic [sbt_pkg::reg_addr_width-1:0]   id_rd_i,
  input logic                                 int_clear_i,
  input logic [sbt_pkg::reg_addr_width-1:0]   int_clear_id_i,
  input logic                                 float_clear_i,
  input logic [sbt_pkg::reg_addr_width-1:0]   float_clear_id_i,
  input logic [sbt_pkg::reg_els-1:0][sbt_pkg::int_classes-1:0]   int_sb_i,
  input logic [sbt_pkg::reg_els-1:0][sbt_pkg::float_classes-1:0] float_sb_i
);

  int fail_cnt = 0;

  reset_empty: assert property (@(posedge clk_i)
    reset_i |=> (int_sb_i == '0) && (float_sb_i == '0))
    else begin
      fail_cnt++;
      $error("scoreboard bit set right after reset");
    end

  // no bit rises unless the id entry leaves this cycle
  rise_needs_set: assert property (@(posedge clk_i) disable iff (reset_i)
    !set_ok_i |=> ((int_sb_i & ~$past(int_sb_i)) == '0) &&
                  ((float_sb_i & ~$past(float_sb_i)) == '0))
    else begin
      fail_cnt++;
      $error("scoreboard bit rose without a set");
    end

  int_clear_empties: assert property (@(posedge clk_i) disable iff (reset_i)
    int_clear_i && !(set_ok_i && id_rd_i == int_clear_id_i)
      |=> int_sb_i[$past(int_clear_id_i)] == '0)
    else begin
      fail_cnt++;
      $error("integer clear left bits behind");
    end

  float_clear_empties: assert property (@(posedge clk_i) disable iff (reset_i)
    float_clear_i && !(set_ok_i && id_rd_i == float_clear_id_i)
      |=> float_sb_i[$past(float_clear_id_i)] == '0)
    else begin
      fail_cnt++;
      $error("float clear left bits behind");
    end

endmodule

bind sbt_tracker sbt_asserts asserts_i (
  .clk_i            (clk_i),
  .reset_i          (reset_i),
  .set_ok_i         (set_ok),
  .id_rd_i          (id_rd_i),
  .int_clear_i      (int_clear_i),
  .int_clear_id_i   (int_clear_id_i),
  .float_clear_i    (float_clear_i),
  .float_clear_id_i (float_clear_id_i),
  .int_sb_i         (int_sb_o),
  .float_sb_i       (float_sb_o)
);

// ==== verification/sbt_checker.sv ====
`timescale 1ns/1ps

module sbt_checker (
  input  logic                                 clk_i,
  input  logic                                 reset_i,
  input  logic                                 instr_valid_i,
  input  logic [31:0]                          instr_i,
  input  logic [sbt_pkg::data_width-1:0]       rs1_val_i,
  input  logic                                 stall_i,
  input  logic                                 flush_i,
  input  logic [sbt_pkg::x_cord_width-1:0]     my_x_i,
  input  logic [sbt_pkg::y_cord_width-1:0]     my_y_i,
  input  logic                                 int_clear_i,
  input  logic [sbt_pkg::reg_addr_width-1:0]   int_clear_id_i,
  input  logic                                 float_clear_i,
  input  logic [sbt_pkg::reg_addr_width-1:0]   float_clear_id_i,
  input  logic [sbt_pkg::reg_els-1:0][sbt_pkg::int_classes-1:0]   int_sb_i,
  input  logic [sbt_pkg::reg_els-1:0][sbt_pkg::float_classes-1:0] float_sb_i,
  input  logic                                 check_i,
  input  int                                   test_id_i,
  input  int                                   exp_int_i,
  input  int                                   exp_float_i,
  output int                                   pass_cnt_o,
  output int                                   fail_cnt_o
);

  logic [sbt_pkg::reg_els-1:0][sbt_pkg::int_classes-1:0]   m_int;
  logic [sbt_pkg::reg_els-1:0][sbt_pkg::float_classes-1:0] m_float;
  logic       id_v;
  logic [4:0] id_rd;
  logic [9:0] id_bits;
  logic       pend;
  int         pend_id;
  int         pend_ei;
  int         pend_ef;
  logic       bad;

  // bits to set for one instruction, float classes on top of integer classes
  function automatic logic [9:0] expect_bits(logic [31:0] ins, logic [31:0] rs1,
                                             logic [5:0] mx, logic [4:0] my);
    logic [31:0] a;
    logic [9:0]  b;
    logic        load;
    logic        fload;
    logic        amo;
    logic        grp;
    b     = '0;
    load  = ins[6:0] == 7'h03;
    fload = (ins[6:0] == 7'h07) && (ins[14:12] == 3'b010);
    amo   = (ins[6:0] == 7'h2f) && (ins[14:12] == 3'b010);
    a     = amo ? rs1 : rs1 + {{20{ins[31]}}, ins[31:20]};
    grp   = (a[31:29] == 3'b001) && (amo || a[23:18] != mx || a[28:24] != my);
    if (ins[6:0] == 7'h33 && ins[31:25] == 7'h01 && ins[14]) b[0] = 1'b1;
    // group_amo, group_load, global_load, dram_amo, dram_load, idiv
    if (load && ins[11:7] != 5'd0) b[5:0] = {1'b0, grp, a[31:30] == 2'b01, 1'b0, a[31], 1'b0};
    if (amo) b[5:0] = {grp, 1'b0, a[31:30] == 2'b01, a[31], 2'b00};
    if (ins[6:0] == 7'h53 && (ins[31:25] == 7'h0c || ins[31:25] == 7'h2c)) b[6] = 1'b1;
    if (fload) b[9:6] = {grp, a[31:30] == 2'b01, a[31], 1'b0};
    return b;
  endfunction

  initial begin
    pass_cnt_o = 0;
    fail_cnt_o = 0;
    pend = 1'b0;
  end

  // reference model, two edges from input to scoreboard
  always @(posedge clk_i) begin
    if (reset_i) begin
      m_int   = '0;
      m_float = '0;
      id_v    = 1'b0;
    end else begin
      if (int_clear_i) m_int[int_clear_id_i] = '0;
      if (float_clear_i) m_float[float_clear_id_i] = '0;
      // set applied after clear so it wins
      if (id_v && !stall_i && !flush_i) begin
        m_int[id_rd]   = m_int[id_rd] | id_bits[5:0];
        m_float[id_rd] = m_float[id_rd] | id_bits[9:6];
      end
      if (flush_i) begin
        id_v = 1'b0;
      end else if (!stall_i) begin
        id_v    = instr_valid_i;
        id_rd   = instr_i[11:7];
        id_bits = expect_bits(instr_i, rs1_val_i, my_x_i, my_y_i);
      end
    end
    pend    = check_i;
    pend_id = test_id_i;
    pend_ei = exp_int_i;
    pend_ef = exp_float_i;
  end

  // outputs settle between edges
  always @(negedge clk_i) begin
    if (pend) begin
      bad = 1'b0;
      if (int_sb_i !== m_int) begin
        $display("Error at %0t ns: int_sb_o expected %h got %h", $time, m_int, int_sb_i);
        bad = 1'b1;
      end
      if (float_sb_i !== m_float) begin
        $display("Error at %0t ns: float_sb_o expected %h got %h", $time, m_float, float_sb_i);
        bad = 1'b1;
      end
      if ($countones(int_sb_i) != pend_ei) begin
        $display("Error at %0t ns: int_sb_o bit count expected %0d got %0d",
                 $time, pend_ei, $countones(int_sb_i));
        bad = 1'b1;
      end
      if ($countones(float_sb_i) != pend_ef) begin
        $display("Error at %0t ns: float_sb_o bit count expected %0d got %0d",
                 $time, pend_ef, $countones(float_sb_i));
        bad = 1'b1;
      end
      if (bad) fail_cnt_o = fail_cnt_o + 1;
      else pass_cnt_o = pass_cnt_o + 1;
      $display("test %0d %s", pend_id, bad ? "failed" : "passed");
    end
  end

endmodule

// ==== verification/sbt_tb.sv ====
`timescale 1ns/1ps

module sbt_tb;

  localparam int period_ns    = 40;
  localparam int reset_cycles = 8;
  localparam logic [31:0] nop = 32'h0000_0013;
  // major opcodes used in the table
  localparam logic [6:0] ld   = 7'h03;
  localparam logic [6:0] fl   = 7'h07;
  localparam logic [6:0] amo  = 7'h2f;
  localparam logic [6:0] op   = 7'h33;
  localparam logic [6:0] opfp = 7'h53;

  typedef struct packed {
    logic [31:0] ins;
    logic [31:0] rs1;
    logic        rnd;
    logic        stall;
    logic        flush;
    logic        ic;
    logic [4:0]  icid;
    logic        fc;
    logic [4:0]  fcid;
    int          hold;
    int          ei;
    int          ef;
  } row_t;

  row_t rows[$];

  logic        clk = 1'b0;
  logic        reset;
  logic        instr_valid;
  logic [31:0] instr;
  logic [31:0] rs1_val;
  logic        stall;
  logic        flush;
  logic [5:0]  my_x;
  logic [4:0]  my_y;
  logic        int_clear;
  logic [4:0]  int_clear_id;
  logic        float_clear;
  logic [4:0]  float_clear_id;
  logic [sbt_pkg::reg_els-1:0][sbt_pkg::int_classes-1:0]   int_sb;
  logic [sbt_pkg::reg_els-1:0][sbt_pkg::float_classes-1:0] float_sb;
  logic        check;
  int          test_id;
  int          exp_int;
  int          exp_float;
  int          pass_cnt;
  int          fail_cnt;
  int          wd_limit;

  always #(period_ns / 2) clk = ~clk;

  sbt_top dut_i (
    .clk_i            (clk),
    .reset_i          (reset),
    .instr_valid_i    (instr_valid),
    .instr_i          (instr),
    .rs1_val_i        (rs1_val),
    .stall_i          (stall),
    .flush_i          (flush),
    .my_x_i           (my_x),
    .my_y_i           (my_y),
    .int_clear_i      (int_clear),
    .int_clear_id_i   (int_clear_id),
    .float_clear_i    (float_clear),
    .float_clear_id_i (float_clear_id),
    .int_sb_o         (int_sb),
    .float_sb_o       (float_sb)
  );

  sbt_checker checker_i (
    .clk_i            (clk),
    .reset_i          (reset),
    .instr_valid_i    (instr_valid),
    .instr_i          (instr),
    .rs1_val_i        (rs1_val),
    .stall_i          (stall),
    .flush_i          (flush),
    .my_x_i           (my_x),
    .my_y_i           (my_y),
    .int_clear_i      (int_clear),
    .int_clear_id_i   (int_clear_id),
    .float_clear_i    (float_clear),
    .float_clear_id_i (float_clear_id),
    .int_sb_i         (int_sb),
    .float_sb_i       (float_sb),
    .check_i          (check),
    .test_id_i        (test_id),
    .exp_int_i        (exp_int),
    .exp_float_i      (exp_float),
    .pass_cnt_o       (pass_cnt),
    .fail_cnt_o       (fail_cnt)
  );

  // i-type word access with rs1 = x1
  function automatic logic [31:0] itype(logic [11:0] imm, logic [4:0] rd, logic [6:0] opc);
    return {imm, 5'd1, 3'b010, rd, opc};
  endfunction

  // r-type with rs1 = x1 and rs2 = x2
  function automatic logic [31:0] rtype(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd,
                                        logic [6:0] opc);
    return {f7, 5'd2, 5'd1, f3, rd, opc};
  endfunction

  task automatic add_row(input logic [31:0] ins, input logic [31:0] rs1, input logic rnd,
                         input logic st, input logic fl_, input logic ic, input logic [4:0] icid,
                         input logic fc, input logic [4:0] fcid, input int hold,
                         input int ei, input int ef);
    rows.push_back('{ins, rs1, rnd, st, fl_, ic, icid, fc, fcid, hold, ei, ef});
  endtask

  initial begin
    row_t r;
    int   seed;
    int   max_hold;
    seed = 32'hdd13;
    max_hold = 1;
    reset = 1'b1;
    instr_valid = 1'b0;
    instr = nop;
    rs1_val = '0;
    stall = 1'b0;
    flush = 1'b0;
    my_x = 6'd3;
    my_y = 5'd2;
    int_clear = 1'b0;
    int_clear_id = '0;
    float_clear = 1'b0;
    float_clear_id = '0;
    check = 1'b0;
    test_id = 0;
    exp_int = 0;
    exp_float = 0;
    // instr                          rs1        rnd st fl ic id fc id hold int fp
    add_row(nop,                      32'h0,        1, 0, 0, 0, 0, 0, 0, 2, 0, 0);
    add_row(itype(12'h000, 1, ld),    32'h80000000, 1, 0, 0, 0, 0, 0, 0, 1, 0, 0);
    add_row(nop,                      32'h0,        0, 0, 0, 0, 0, 0, 0, 1, 1, 0);
    add_row(itype(12'h000, 2, ld),    32'h40000000, 1, 0, 0, 0, 0, 0, 0, 2, 2, 0);
    add_row(itype(12'h010, 3, ld),    32'h21140000, 0, 0, 0, 0, 0, 0, 0, 2, 3, 0);
    // negative offset walks down into the group region
    add_row(itype(12'hffc, 4, ld),    32'h40000000, 0, 0, 0, 0, 0, 0, 0, 2, 4, 0);
    // own tile sits at x 3 and y 2
    add_row(itype(12'h000, 5, ld),    32'h220c0000, 0, 0, 0, 0, 0, 0, 0, 2, 4, 0);
    add_row(rtype(7'h00, 3'b010, 6, amo), 32'h220c0000, 0, 0, 0, 0, 0, 0, 0, 2, 5, 0);
    add_row(rtype(7'h00, 3'b010, 7, amo), 32'h40000100, 0, 0, 0, 0, 0, 0, 0, 2, 6, 0);
    add_row(rtype(7'h00, 3'b010, 8, amo), 32'h80000000, 1, 0, 0, 0, 0, 0, 0, 2, 7, 0);
    add_row(rtype(7'h01, 3'b100, 2, op),  32'h0,        0, 0, 0, 0, 0, 0, 0, 2, 8, 0);
    add_row(rtype(7'h0c, 3'b000, 1, opfp), 32'h0,       0, 0, 0, 0, 0, 0, 0, 2, 8, 1);
    add_row(rtype(7'h2c, 3'b000, 2, opfp), 32'h0,       0, 0, 0, 0, 0, 0, 0, 2, 8, 2);
    add_row(itype(12'h000, 3, fl),    32'h80000000, 1, 0, 0, 0, 0, 0, 0, 2, 8, 3);
    add_row(itype(12'h000, 4, fl),    32'h40000000, 1, 0, 0, 0, 0, 0, 0, 2, 8, 4);
    add_row(itype(12'h010, 5, fl),    32'h21140000, 0, 0, 0, 0, 0, 0, 0, 2, 8, 5);
    add_row(itype(12'h000, 0, ld),    32'h80000000, 0, 0, 0, 0, 0, 0, 0, 2, 8, 5);
    // stall holds the entry in id
    add_row(itype(12'h000, 10, ld),   32'h80000000, 0, 0, 0, 0, 0, 0, 0, 1, 8, 5);
    add_row(nop,                      32'h0,        0, 1, 0, 0, 0, 0, 0, 3, 8, 5);
    add_row(nop,                      32'h0,        0, 0, 0, 0, 0, 0, 0, 1, 9, 5);
    add_row(itype(12'h000, 12, ld),   32'h80000000, 0, 0, 0, 0, 0, 0, 0, 1, 9, 5);
    // flush kills the entry in id and drops the load presented with it
    add_row(itype(12'h000, 13, ld),   32'h80000000, 0, 0, 1, 0, 0, 0, 0, 1, 9, 5);
    add_row(nop,                      32'h0,        0, 0, 0, 0, 0, 0, 0, 2, 9, 5);
    // clears and then clear with set on the same register
    add_row(nop,                      32'h0,        0, 0, 0, 1, 2, 1, 1, 1, 7, 4);
    add_row(itype(12'h000, 3, ld),    32'h80000000, 0, 0, 0, 0, 0, 0, 0, 1, 7, 4);
    add_row(nop,                      32'h0,        0, 0, 0, 1, 3, 0, 0, 2, 7, 4);
    add_row(itype(12'h000, 3, fl),    32'h40000000, 0, 0, 0, 0, 0, 0, 0, 1, 7, 4);
    add_row(nop,                      32'h0,        0, 0, 0, 0, 0, 1, 3, 2, 7, 4);
    add_row(nop,                      32'h0,        1, 0, 0, 0, 0, 0, 0, 2, 7, 4);
    foreach (rows[n]) begin
      if (rows[n].hold > max_hold) max_hold = rows[n].hold;
    end
    wd_limit = (reset_cycles + rows.size() * max_hold + 16) * period_ns;

    repeat (reset_cycles) @(negedge clk);
    reset = 1'b0;
    foreach (rows[n]) begin
      r = rows[n];
      instr_valid = 1'b1;
      instr = r.ins;
      rs1_val = r.rnd ? (r.rs1 | ($random(seed) & 32'h0fff_fffc)) : r.rs1;
      stall = r.stall;
      flush = r.flush;
      int_clear = r.ic;
      int_clear_id = r.icid;
      float_clear = r.fc;
      float_clear_id = r.fcid;
      test_id = n;
      exp_int = r.ei;
      exp_float = r.ef;
      check = (r.hold == 1);
      // strobes last one cycle while stall and flush hold for the row
      for (int c = 1; c < r.hold; c++) begin
        @(negedge clk);
        instr_valid = 1'b0;
        int_clear = 1'b0;
        float_clear = 1'b0;
        check = (c == r.hold - 1);
      end
      @(negedge clk);
    end
    check = 1'b0;
    instr_valid = 1'b0;
    repeat (2) @(negedge clk);

    $display("tests passed %0d, failed %0d, assertion failures %0d", pass_cnt, fail_cnt,
             dut_i.tracker_i.asserts_i.fail_cnt);
    if (fail_cnt == 0 && pass_cnt == rows.size() && dut_i.tracker_i.asserts_i.fail_cnt == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

  // watchdog sized from the table
  initial begin
    #1;
    #(wd_limit);
    $display("watchdog expired before all table rows were applied");
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule
